// ==== hdl/spmv_pkg.sv ====
package spmv_pkg;

    // widths with a meaning of their own
    typedef logic [47:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [47:0] reg_val_t;
    typedef logic [1:0]  dec_tag_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  pe_id_t;
    typedef logic [2:0]  rsp_tag_t;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_RST    = 3'd1,
        OP_STEADY = 3'd2,
        OP_LD     = 3'd3,
        OP_READ   = 3'd4,
        OP_RETURN = 3'd5
    } op_code_e;

    // ring word, msb first
    typedef struct packed {
        logic [51:0] data;
        reg_idx_t    reg_idx;
        logic        broadcast;
        pe_id_t      pe_id;
        op_code_e    opcode;
    } op_word_t;

    // loads carry source in bit 0 and decoder tag in bits 2:1
    typedef struct packed {
        logic  ld;
        logic  st;
        addr_t addr;
        word_t d_or_tag;
    } mem_req_t;

    typedef struct packed {
        rsp_tag_t tag;
        word_t    q;
    } mem_rsp_t;

    localparam reg_idx_t REG_Y_ADDR = 4'd0;
    localparam reg_idx_t REG_Y_END  = 4'd1;

    localparam addr_t Y_STRIDE = 48'd8;

    localparam int SRC_DEPTH   = 32;
    localparam int ISSUE_DEPTH = 32;

    localparam int IDX_AF   = 8;
    localparam int X_AF     = 8;
    localparam int RES_AF   = 8;
    localparam int ISSUE_AF = 4;

    localparam int STEADY_TIMEOUT_BIT = 5;

endpackage

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH             = 64,
    parameter int DEPTH             = 32,
    parameter int ALMOST_FULL_COUNT = 8,
    parameter bit SHOW_AHEAD        = 1'b0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // push into a full queue is lost, pop of an empty one ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (CNT_W'(DEPTH) - count) <= CNT_W'(ALMOST_FULL_COUNT);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= d;
        end
    end

    generate
        if (SHOW_AHEAD) begin : g_show_ahead
            // head visible before the pop
            assign q = mem[rd_ptr];
        end else begin : g_registered
            logic [WIDTH-1:0] q_r;
            always_ff @(posedge clk) begin
                if (do_pop) begin
                    q_r <= mem[rd_ptr];
                end
            end
            assign q = q_r;
        end
    endgenerate

endmodule

// ==== hdl/op_ring_ctrl.sv ====
`timescale 1ns/100ps

module op_ring_ctrl #(
    parameter spmv_pkg::pe_id_t PE_ID = 4'd0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  spmv_pkg::op_word_t op_in,
    output spmv_pkg::op_word_t op_out,
    input  logic               busy_in,
    output logic               busy_out,
    input  logic               store_slot,
    input  logic               issue_idle,
    output logic               flush,
    output spmv_pkg::addr_t    y_addr,
    output logic               y_done
);

    import spmv_pkg::*;

    typedef enum logic {
        IDLE,
        STEADY
    } state_e;

    state_e   state_q;
    state_e   state_d;
    op_word_t op_in_q;
    op_word_t op_q;
    op_word_t op_out_q;
    op_word_t op_out_d;
    reg_val_t y_addr_q;
    reg_val_t y_end_q;
    reg_val_t rd_val;
    logic     busy_in_q;
    logic     busy_out_q;
    logic     addressed;
    logic     rd_valid;
    logic     drained;
    logic [STEADY_TIMEOUT_BIT:0] drain_timer;

    // second ring stage is the decode point
    assign addressed = op_q.broadcast || (op_q.pe_id == PE_ID);
    assign rd_valid  = (op_q.reg_idx == REG_Y_ADDR) || (op_q.reg_idx == REG_Y_END);
    assign rd_val    = (op_q.reg_idx == REG_Y_END) ? y_end_q : y_addr_q;

    assign flush   = addressed && (op_q.opcode == OP_RST);
    assign y_done  = (y_addr_q == y_end_q);
    assign drained = y_done && issue_idle;

    // return word overwrites the slot after the read
    always_comb begin
        op_out_d = op_in_q;
        if (addressed && op_q.opcode == OP_READ && rd_valid) begin
            op_out_d.opcode    = OP_RETURN;
            op_out_d.pe_id     = PE_ID;
            op_out_d.broadcast = 1'b0;
            op_out_d.reg_idx   = op_q.reg_idx;
            op_out_d.data      = 52'(rd_val);
        end
    end

    always_comb begin
        state_d = state_q;
        if (state_q == STEADY && drain_timer[STEADY_TIMEOUT_BIT]) begin
            state_d = IDLE;
        end
        if (addressed) begin
            case (op_q.opcode)
                OP_RST:    state_d = IDLE;
                OP_STEADY: state_d = STEADY;
                default:   state_d = state_d;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_in_q    <= '0;
            op_q       <= '0;
            op_out_q   <= '0;
            busy_in_q  <= 1'b0;
            busy_out_q <= 1'b0;
            state_q    <= IDLE;
        end else begin
            op_in_q    <= op_in;
            op_q       <= op_in_q;
            op_out_q   <= op_out_d;
            busy_in_q  <= busy_in;
            busy_out_q <= (state_q == STEADY) || busy_in_q;
            state_q    <= state_d;
        end
    end

    // counts drained cycles while steady, holds at the timeout bit
    always_ff @(posedge clk) begin
        if (!rst_n || state_q == IDLE || !drained) begin
            drain_timer <= '0;
        end else if (!drain_timer[STEADY_TIMEOUT_BIT]) begin
            drain_timer <= drain_timer + 1'b1;
        end
    end

    // a load in the same cycle wins over the store step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            y_addr_q <= '0;
            y_end_q  <= '0;
        end else begin
            if (store_slot && !y_done) begin
                y_addr_q <= y_addr_q + Y_STRIDE;
            end
            if (addressed && op_q.opcode == OP_LD) begin
                case (op_q.reg_idx)
                    REG_Y_ADDR: y_addr_q <= reg_val_t'(op_q.data);
                    REG_Y_END:  y_end_q  <= reg_val_t'(op_q.data);
                    default:    y_end_q  <= y_end_q;
                endcase
            end
        end
    end

    assign op_out   = op_out_q;
    assign busy_out = busy_out_q;
    assign y_addr   = y_addr_q;

endmodule

// ==== hdl/mem_req_arbiter.sv ====
`timescale 1ns/100ps

module mem_req_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                idx_req_push,
    input  spmv_pkg::addr_t     idx_req_addr,
    input  spmv_pkg::dec_tag_t  idx_req_tag,
    output logic                idx_req_stall,
    input  logic                x_req_push,
    input  spmv_pkg::addr_t     x_req_addr,
    output logic                x_req_stall,
    input  logic                res_push,
    input  spmv_pkg::word_t     res_data,
    output logic                res_stall,
    input  spmv_pkg::addr_t     y_addr,
    input  logic                y_done,
    input  logic                issue_af,
    output logic                issue_push,
    output spmv_pkg::mem_req_t  issue_req,
    output logic                store_slot
);

    import spmv_pkg::*;

    typedef struct packed {
        addr_t    addr;
        dec_tag_t tag;
    } idx_entry_t;

    idx_entry_t idx_d;
    idx_entry_t idx_q;
    addr_t      x_q;
    word_t      res_q;
    logic       idx_empty;
    logic       x_empty;
    logic       res_empty;
    logic       idx_af;
    logic       x_af;
    logic       res_af;
    logic       idx_pop;
    logic       x_pop;
    logic       res_pop;
    logic       idx_sel_q;
    logic       x_sel_q;
    logic       res_sel_q;
    logic       idx_af_q;
    logic       push_q;
    mem_req_t   req_d;
    mem_req_t   req_q;

    assign idx_d = '{addr: idx_req_addr, tag: idx_req_tag};

    sync_fifo #(
        .WIDTH($bits(idx_entry_t)), .DEPTH(SRC_DEPTH),
        .ALMOST_FULL_COUNT(IDX_AF), .SHOW_AHEAD(1'b0)
    ) i_idx_fifo (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(idx_req_push), .pop(idx_pop), .d(idx_d), .q(idx_q),
        .empty(idx_empty), .full(), .almost_full(idx_af)
    );

    sync_fifo #(
        .WIDTH($bits(addr_t)), .DEPTH(SRC_DEPTH),
        .ALMOST_FULL_COUNT(X_AF), .SHOW_AHEAD(1'b0)
    ) i_x_fifo (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(x_req_push), .pop(x_pop), .d(x_req_addr), .q(x_q),
        .empty(x_empty), .full(), .almost_full(x_af)
    );

    sync_fifo #(
        .WIDTH($bits(word_t)), .DEPTH(SRC_DEPTH),
        .ALMOST_FULL_COUNT(RES_AF), .SHOW_AHEAD(1'b0)
    ) i_res_fifo (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(res_push), .pop(res_pop), .d(res_data), .q(res_q),
        .empty(res_empty), .full(), .almost_full(res_af)
    );

    // results first, then x loads, then index loads
    always_comb begin
        res_pop = 1'b0;
        x_pop   = 1'b0;
        idx_pop = 1'b0;
        if (!issue_af) begin
            if (!res_empty) begin
                res_pop = 1'b1;
            end else if (!x_empty) begin
                x_pop = 1'b1;
            end else if (!idx_empty) begin
                idx_pop = 1'b1;
            end
        end
    end

    // queue outputs are valid one cycle after the pop
    always_comb begin
        req_d = '0;
        if (res_sel_q) begin
            req_d.st       = !y_done;
            req_d.addr     = y_addr;
            req_d.d_or_tag = res_q;
        end else if (x_sel_q) begin
            req_d.ld          = 1'b1;
            req_d.addr        = x_q;
            req_d.d_or_tag[0] = 1'b1;
        end else if (idx_sel_q) begin
            req_d.ld            = 1'b1;
            req_d.addr          = idx_q.addr;
            req_d.d_or_tag[2:1] = idx_q.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            res_sel_q <= 1'b0;
            x_sel_q   <= 1'b0;
            idx_sel_q <= 1'b0;
            push_q    <= 1'b0;
        end else begin
            res_sel_q <= res_pop;
            x_sel_q   <= x_pop;
            idx_sel_q <= idx_pop;
            push_q    <= req_d.ld || req_d.st;
        end
    end

    always_ff @(posedge clk) begin
        req_q <= req_d;
    end

    // index stall also throttles the x cache upstream, hence two stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_stall     <= 1'b0;
            x_req_stall   <= 1'b0;
            idx_af_q      <= 1'b0;
            idx_req_stall <= 1'b0;
        end else begin
            res_stall     <= res_af;
            x_req_stall   <= x_af;
            idx_af_q      <= idx_af;
            idx_req_stall <= idx_af_q;
        end
    end

    // y address advances on every popped result, even a dropped one
    assign store_slot = res_sel_q;
    assign issue_push = push_q;
    assign issue_req  = req_q;

endmodule

// ==== hdl/mem_port.sv ====
`timescale 1ns/100ps

module mem_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               issue_push,
    input  spmv_pkg::mem_req_t issue_req,
    output logic               issue_af,
    output logic               issue_idle,
    output spmv_pkg::mem_req_t req_mem,
    input  logic               req_mem_stall,
    input  logic               rsp_mem_push,
    input  spmv_pkg::mem_rsp_t rsp_mem,
    output logic               rsp_mem_stall,
    output logic               idx_rsp_push,
    output spmv_pkg::dec_tag_t idx_rsp_tag,
    output spmv_pkg::word_t    idx_rsp_q,
    input  logic               idx_rsp_stall,
    output logic               x_rsp_push,
    output spmv_pkg::word_t    x_rsp_q
);

    import spmv_pkg::*;

    mem_req_t head;
    mem_req_t req_q;
    mem_rsp_t rsp_q;
    logic     issue_empty;
    logic     issue_pop;
    logic     stall_q;
    logic     rsp_push_q;

    sync_fifo #(
        .WIDTH($bits(mem_req_t)), .DEPTH(ISSUE_DEPTH),
        .ALMOST_FULL_COUNT(ISSUE_AF), .SHOW_AHEAD(1'b1)
    ) i_issue_fifo (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .push(issue_push), .pop(issue_pop), .d(issue_req), .q(head),
        .empty(issue_empty), .full(), .almost_full(issue_af)
    );

    // registered stall, memory sees up to two more requests
    assign issue_pop  = !issue_empty && !stall_q;
    assign issue_idle = issue_empty;

    always_ff @(posedge clk) begin
        req_q <= head;
        if (!rst_n || !issue_pop) begin
            req_q.ld <= 1'b0;
            req_q.st <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_q       <= 1'b0;
            rsp_push_q    <= 1'b0;
            rsp_mem_stall <= 1'b0;
        end else begin
            stall_q       <= req_mem_stall;
            rsp_push_q    <= rsp_mem_push;
            rsp_mem_stall <= idx_rsp_stall;
        end
    end

    always_ff @(posedge clk) begin
        rsp_q <= rsp_mem;
    end

    // tag bit 0 picks the consumer
    assign idx_rsp_push = rsp_push_q && !rsp_q.tag[0];
    assign idx_rsp_tag  = rsp_q.tag[2:1];
    assign idx_rsp_q    = rsp_q.q;
    assign x_rsp_push   = rsp_push_q && rsp_q.tag[0];
    assign x_rsp_q      = rsp_q.q;

    assign req_mem = req_q;

endmodule

// ==== hdl/spmv_pe.sv ====
`timescale 1ns/100ps

module spmv_pe #(
    parameter spmv_pkg::pe_id_t PE_ID = 4'd0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  spmv_pkg::op_word_t op_in,
    output spmv_pkg::op_word_t op_out,
    input  logic               busy_in,
    output logic               busy_out,
    input  logic               idx_req_push,
    input  spmv_pkg::addr_t    idx_req_addr,
    input  spmv_pkg::dec_tag_t idx_req_tag,
    output logic               idx_req_stall,
    input  logic               x_req_push,
    input  spmv_pkg::addr_t    x_req_addr,
    output logic               x_req_stall,
    input  logic               res_push,
    input  spmv_pkg::word_t    res_data,
    output logic               res_stall,
    output spmv_pkg::mem_req_t req_mem,
    input  logic               req_mem_stall,
    input  logic               rsp_mem_push,
    input  spmv_pkg::mem_rsp_t rsp_mem,
    output logic               rsp_mem_stall,
    output logic               idx_rsp_push,
    output spmv_pkg::dec_tag_t idx_rsp_tag,
    output spmv_pkg::word_t    idx_rsp_q,
    input  logic               idx_rsp_stall,
    output logic               x_rsp_push,
    output spmv_pkg::word_t    x_rsp_q
);

    import spmv_pkg::*;

    logic     flush;
    addr_t    y_addr;
    logic     y_done;
    logic     store_slot;
    logic     issue_push;
    mem_req_t issue_req;
    logic     issue_af;
    logic     issue_idle;

    op_ring_ctrl #(.PE_ID(PE_ID)) i_ctrl (
        .clk(clk), .rst_n(rst_n),
        .op_in(op_in), .op_out(op_out),
        .busy_in(busy_in), .busy_out(busy_out),
        .store_slot(store_slot), .issue_idle(issue_idle),
        .flush(flush), .y_addr(y_addr), .y_done(y_done)
    );

    mem_req_arbiter i_arb (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .idx_req_push(idx_req_push), .idx_req_addr(idx_req_addr),
        .idx_req_tag(idx_req_tag), .idx_req_stall(idx_req_stall),
        .x_req_push(x_req_push), .x_req_addr(x_req_addr), .x_req_stall(x_req_stall),
        .res_push(res_push), .res_data(res_data), .res_stall(res_stall),
        .y_addr(y_addr), .y_done(y_done), .issue_af(issue_af),
        .issue_push(issue_push), .issue_req(issue_req), .store_slot(store_slot)
    );

    mem_port i_port (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .issue_push(issue_push), .issue_req(issue_req),
        .issue_af(issue_af), .issue_idle(issue_idle),
        .req_mem(req_mem), .req_mem_stall(req_mem_stall),
        .rsp_mem_push(rsp_mem_push), .rsp_mem(rsp_mem), .rsp_mem_stall(rsp_mem_stall),
        .idx_rsp_push(idx_rsp_push), .idx_rsp_tag(idx_rsp_tag), .idx_rsp_q(idx_rsp_q),
        .idx_rsp_stall(idx_rsp_stall),
        .x_rsp_push(x_rsp_push), .x_rsp_q(x_rsp_q)
    );

endmodule

// ==== sim/tb_spmv_pe.sv ====
`timescale 1ns/100ps

module tb_spmv_pe;

    import spmv_pkg::*;

    localparam pe_id_t MY_ID = 4'd3;

    // one table row, inputs for one cycle and the outputs expected from them
    typedef struct packed {
        op_word_t op;
        logic     busy;
        logic     res;
        word_t    res_d;
        logic     x;
        addr_t    x_a;
        logic     idx;
        addr_t    idx_a;
        dec_tag_t idx_t;
        logic     stall;
        logic     rsp;
        mem_rsp_t rsp_d;
        logic     irs;
        logic     chk;
        // read that should come back as a return word
        logic     rtn;
        reg_val_t ret;
        // consumer that should see the response
        logic     to_idx;
        logic     to_x;
        dec_tag_t rsp_t;
    } step_t;

    logic     clk = 1'b0;
    logic     rst_n;
    op_word_t op_in;
    op_word_t op_out;
    logic     busy_in;
    logic     busy_out;
    logic     idx_req_push;
    addr_t    idx_req_addr;
    dec_tag_t idx_req_tag;
    logic     idx_req_stall;
    logic     x_req_push;
    addr_t    x_req_addr;
    logic     x_req_stall;
    logic     res_push;
    word_t    res_data;
    logic     res_stall;
    mem_req_t req_mem;
    logic     req_mem_stall;
    logic     rsp_mem_push;
    mem_rsp_t rsp_mem;
    logic     rsp_mem_stall;
    logic     idx_rsp_push;
    dec_tag_t idx_rsp_tag;
    word_t    idx_rsp_q;
    logic     idx_rsp_stall;
    logic     x_rsp_push;
    word_t    x_rsp_q;

    step_t       steps[$];
    mem_req_t    exp_req[$];
    mem_req_t    got_req[$];
    int          errors = 0;
    int          tests = 0;
    logic [31:0] seed = 32'hd467_1459;
    logic [1:0]  stall_hist = 2'b00;

    spmv_pe #(.PE_ID(MY_ID)) i_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        stall_hist <= {stall_hist[0], req_mem_stall};
    end

    // collect requests and flag any issued under the registered stall
    always @(negedge clk) begin
        if (rst_n === 1'b1 && (req_mem.ld || req_mem.st)) begin
            got_req.push_back(req_mem);
            if (stall_hist[1]) begin
                errors++;
                $display("request issued at %0t although the memory stall was held", $time);
            end
        end
    end

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic addr_t rand_addr();
        logic [31:0] hi;
        hi = lcg();
        return {hi[15:0], lcg()};
    endfunction

    function automatic op_word_t mk_op(op_code_e c, pe_id_t pe, logic bc, reg_idx_t idx,
                                       logic [51:0] data);
        op_word_t w;
        w.opcode    = c;
        w.pe_id     = pe;
        w.broadcast = bc;
        w.reg_idx   = idx;
        w.data      = data;
        return w;
    endfunction

    function automatic step_t row(op_word_t op);
        step_t s;
        s     = '0;
        s.op  = op;
        s.chk = 1'b1;
        return s;
    endfunction

    task automatic compare(string name, logic [127:0] exp, logic [127:0] got);
        if (exp !== got) begin
            errors++;
            $display("ERR %0t %s exp %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic add_nops(int n, logic stall, logic chk);
        step_t s;
        for (int i = 0; i < n; i++) begin
            s       = row('0);
            s.stall = stall;
            s.chk   = chk;
            steps.push_back(s);
        end
    endtask

    task automatic drive(step_t s);
        op_in         = s.op;
        busy_in       = s.busy;
        res_push      = s.res;
        res_data      = s.res_d;
        x_req_push    = s.x;
        x_req_addr    = s.x_a;
        idx_req_push  = s.idx;
        idx_req_addr  = s.idx_a;
        idx_req_tag   = s.idx_t;
        req_mem_stall = s.stall;
        rsp_mem_push  = s.rsp;
        rsp_mem       = s.rsp_d;
        idx_rsp_stall = s.irs;
    endtask

    // ring output lags its input by two steps and a return replaces the word after the read
    task automatic run_steps();
        op_word_t e;
        step_t    p;
        for (int j = 0; j < steps.size(); j++) begin
            @(negedge clk);
            if (j >= 3 && steps[j-2].chk) begin
                e = steps[j-2].op;
                if (steps[j-3].rtn) begin
                    e = mk_op(OP_RETURN, MY_ID, 1'b0, steps[j-3].op.reg_idx,
                              52'(steps[j-3].ret));
                end
                compare("op_out", e, op_out);
                compare("busy_out", steps[j-2].busy, busy_out);
            end
            if (j >= 1) begin
                p = steps[j-1];
                compare("rsp_mem_stall", p.irs, rsp_mem_stall);
                compare("idx_rsp_push", p.to_idx, idx_rsp_push);
                compare("x_rsp_push", p.to_x, x_rsp_push);
                if (p.to_x) begin
                    compare("x_rsp_q", p.rsp_d.q, x_rsp_q);
                end
                if (p.to_idx) begin
                    compare("idx_rsp_tag", p.rsp_t, idx_rsp_tag);
                    compare("idx_rsp_q", p.rsp_d.q, idx_rsp_q);
                end
            end
            drive(steps[j]);
        end
        @(negedge clk);
        op_in        = '0;
        res_push     = 1'b0;
        x_req_push   = 1'b0;
        idx_req_push = 1'b0;
        rsp_mem_push = 1'b0;
        steps.delete();
    endtask

    task automatic finish_test(string name, int start_err);
        int cnt;
        cnt = 0;
        while (got_req.size() < exp_req.size() && cnt < 200) begin
            @(negedge clk);
            cnt++;
        end
        if (got_req.size() < exp_req.size()) begin
            errors++;
            $display("timeout in %s: only %0d of %0d memory requests arrived",
                     name, got_req.size(), exp_req.size());
        end
        // late extra requests would show up here
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
        end
        compare("req_mem count", exp_req.size(), got_req.size());
        for (int i = 0; i < exp_req.size() && i < got_req.size(); i++) begin
            compare($sformatf("req_mem[%0d]", i), exp_req[i], got_req[i]);
        end
        exp_req.delete();
        got_req.delete();
        tests++;
        $display("%s: %s", name, (errors == start_err) ? "ok" : "failed");
    endtask

    task automatic ring_pass_through();
        int    e0;
        step_t s;
        e0 = errors;
        compare("op_out", '0, op_out);
        compare("busy_out", 0, busy_out);
        compare("req_mem.ld", 0, req_mem.ld);
        compare("req_mem.st", 0, req_mem.st);
        compare("idx_req_stall", 0, idx_req_stall);
        compare("x_req_stall", 0, x_req_stall);
        compare("res_stall", 0, res_stall);
        compare("rsp_mem_stall", 0, rsp_mem_stall);
        compare("idx_rsp_push", 0, idx_rsp_push);
        compare("x_rsp_push", 0, x_rsp_push);
        add_nops(1, 1'b0, 1'b1);
        steps.push_back(row(mk_op(OP_LD, 4'd5, 1'b0, REG_Y_ADDR, 52'(lcg()))));
        s      = row(mk_op(OP_NOP, 4'd9, 1'b0, 4'd2, 52'(lcg())));
        s.busy = 1'b1;
        steps.push_back(s);
        steps.push_back(row(mk_op(OP_READ, 4'd7, 1'b0, REG_Y_END, '0)));
        s      = row(mk_op(OP_STEADY, 4'd1, 1'b0, 4'd0, 52'(lcg())));
        s.busy = 1'b1;
        steps.push_back(s);
        add_nops(3, 1'b0, 1'b1);
        run_steps();
        finish_test("reset and pass-through", e0);
    endtask

    task automatic load_and_read();
        int    e0;
        addr_t va;
        addr_t ve;
        step_t s;
        e0 = errors;
        va = rand_addr();
        ve = rand_addr();
        add_nops(1, 1'b0, 1'b1);
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_ADDR, 52'(va))));
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_END, 52'(ve))));
        s     = row(mk_op(OP_READ, MY_ID, 1'b0, REG_Y_ADDR, '0));
        s.rtn = 1'b1;
        s.ret = va;
        steps.push_back(s);
        add_nops(1, 1'b0, 1'b1);
        s     = row(mk_op(OP_READ, MY_ID, 1'b0, REG_Y_END, '0));
        s.rtn = 1'b1;
        s.ret = ve;
        steps.push_back(s);
        add_nops(1, 1'b0, 1'b1);
        s     = row(mk_op(OP_READ, 4'd0, 1'b1, REG_Y_ADDR, '0));
        s.rtn = 1'b1;
        s.ret = va;
        steps.push_back(s);
        add_nops(1, 1'b0, 1'b1);
        steps.push_back(row(mk_op(OP_READ, MY_ID, 1'b0, 4'd2, 52'h5a5)));
        add_nops(4, 1'b0, 1'b1);
        run_steps();
        finish_test("load and read", e0);
    endtask

    task automatic stores_and_limit();
        int    e0;
        word_t d[3];
        step_t s;
        e0 = errors;
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_ADDR, 52'h1000)));
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_END, 52'h1010)));
        add_nops(2, 1'b0, 1'b1);
        for (int i = 0; i < 3; i++) begin
            d[i]    = {lcg(), lcg()};
            s       = row('0);
            s.res   = 1'b1;
            s.res_d = d[i];
            steps.push_back(s);
        end
        add_nops(8, 1'b0, 1'b1);
        s     = row(mk_op(OP_READ, MY_ID, 1'b0, REG_Y_ADDR, '0));
        s.rtn = 1'b1;
        s.ret = 48'h1010;
        steps.push_back(s);
        add_nops(4, 1'b0, 1'b1);
        exp_req.push_back(mem_req_t'{ld: 1'b0, st: 1'b1, addr: 48'h1000, d_or_tag: d[0]});
        exp_req.push_back(mem_req_t'{ld: 1'b0, st: 1'b1, addr: 48'h1008, d_or_tag: d[1]});
        run_steps();
        finish_test("stores and y limit", e0);
    endtask

    task automatic priority_and_stall();
        int    e0;
        step_t s;
        e0 = errors;
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_ADDR, 52'h2000)));
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_END, 52'h3000)));
        add_nops(2, 1'b0, 1'b1);
        add_nops(1, 1'b1, 1'b1);
        s       = row('0);
        s.stall = 1'b1;
        s.res   = 1'b1;
        s.res_d = {lcg(), lcg()};
        s.x     = 1'b1;
        s.x_a   = rand_addr();
        s.idx   = 1'b1;
        s.idx_a = rand_addr();
        s.idx_t = 2'd3;
        steps.push_back(s);
        add_nops(6, 1'b1, 1'b1);
        add_nops(4, 1'b0, 1'b1);
        exp_req.push_back(mem_req_t'{ld: 1'b0, st: 1'b1, addr: 48'h2000, d_or_tag: s.res_d});
        exp_req.push_back(mem_req_t'{ld: 1'b1, st: 1'b0, addr: s.x_a, d_or_tag: 64'd1});
        exp_req.push_back(mem_req_t'{ld: 1'b1, st: 1'b0, addr: s.idx_a, d_or_tag: 64'd6});
        run_steps();
        finish_test("priority and back-pressure", e0);
    endtask

    task automatic response_routing();
        int    e0;
        step_t s;
        e0 = errors;
        add_nops(1, 1'b0, 1'b1);
        s        = row('0);
        s.rsp    = 1'b1;
        s.rsp_d  = mem_rsp_t'{tag: 3'b100, q: {lcg(), lcg()}};
        s.to_idx = 1'b1;
        s.rsp_t  = 2'd2;
        steps.push_back(s);
        s        = row('0);
        s.rsp    = 1'b1;
        s.rsp_d  = mem_rsp_t'{tag: 3'b011, q: {lcg(), lcg()}};
        s.to_x   = 1'b1;
        steps.push_back(s);
        s        = row('0);
        s.irs    = 1'b1;
        steps.push_back(s);
        s.rsp    = 1'b1;
        s.rsp_d  = mem_rsp_t'{tag: 3'b010, q: {lcg(), lcg()}};
        s.to_idx = 1'b1;
        s.rsp_t  = 2'd1;
        steps.push_back(s);
        add_nops(4, 1'b0, 1'b1);
        run_steps();
        finish_test("response routing", e0);
    endtask

    task automatic steady_and_soft_reset();
        int    e0;
        int    cnt;
        step_t s;
        e0 = errors;
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_ADDR, 52'h4000)));
        steps.push_back(row(mk_op(OP_LD, MY_ID, 1'b0, REG_Y_END, 52'h4000)));
        add_nops(2, 1'b0, 1'b1);
        s     = row(mk_op(OP_STEADY, MY_ID, 1'b0, 4'd0, '0));
        s.chk = 1'b0;
        steps.push_back(s);
        add_nops(3, 1'b0, 1'b0);
        run_steps();
        cnt = 0;
        while (busy_out !== 1'b1 && cnt < 10) begin
            @(negedge clk);
            cnt++;
        end
        if (busy_out !== 1'b1) begin
            errors++;
            $display("timeout: busy_out did not rise after the steady operation");
        end
        cnt = 0;
        while (busy_out !== 1'b0 && cnt < 40) begin
            @(negedge clk);
            cnt++;
        end
        if (busy_out !== 1'b0) begin
            errors++;
            $display("timeout: busy_out stayed high after the PE drained");
        end
        // x load parked behind the memory stall before the soft reset
        add_nops(1, 1'b1, 1'b1);
        s       = row('0);
        s.stall = 1'b1;
        s.x     = 1'b1;
        s.x_a   = rand_addr();
        steps.push_back(s);
        add_nops(4, 1'b1, 1'b1);
        s       = row(mk_op(OP_RST, MY_ID, 1'b0, 4'd0, '0));
        s.stall = 1'b1;
        steps.push_back(s);
        add_nops(3, 1'b1, 1'b1);
        add_nops(4, 1'b0, 1'b1);
        run_steps();
        finish_test("steady state and soft reset", e0);
    endtask

    initial begin
        rst_n = 1'b0;
        drive('0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        ring_pass_through();
        load_and_read();
        stores_and_limit();
        priority_and_stall();
        response_routing();
        steady_and_soft_reset();
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/spmv_pkg.sv
hdl/sync_fifo.sv
hdl/op_ring_ctrl.sv
hdl/mem_req_arbiter.sv
hdl/mem_port.sv
hdl/spmv_pe.sv
sim/tb_spmv_pe.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -Wno-fatal
TOP       ?= tb_spmv_pe
FILELIST  ?= all.f
SIM_BIN   := obj_dir/sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the pipe status is grep's, so a missing pass line fails the target
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
